//--- files.f
hw/wbaxi_pkg.sv
hw/wbaxi_ctrl.sv
hw/axil_req_issue.sv
hw/axil_resp_return.sv
hw/axil_txn_monitor.sv
hw/wbaxi_bridge_top.sv
testbench/wbaxi_assertions.sv
testbench/tb_wbaxi_bridge.sv

//--- hw/axil_req_issue.sv
`timescale 1ns/1ps
`default_nettype none

module axil_req_issue #(
	parameter int ADDR_WIDTH = 28
) (
	input wire i_clk,
	input wire i_axi_reset_n,

	// Request from control, payload straight off Wishbone
	input wire i_load,
	input wire i_write,
	input wire [ADDR_WIDTH-3:0] i_wb_addr,
	input wire wbaxi_pkg::axi_data_t i_wb_data,
	input wire wbaxi_pkg::axi_strb_t i_wb_sel,

	input wire i_axi_awready,
	input wire i_axi_wready,
	input wire i_axi_arready,

	output logic o_busy,
	output logic o_axi_awvalid,
	output logic [ADDR_WIDTH-1:0] o_axi_awaddr,
	output logic [2:0] o_axi_awprot,
	output logic o_axi_wvalid,
	output wbaxi_pkg::axi_data_t o_axi_wdata,
	output wbaxi_pkg::axi_strb_t o_axi_wstrb,
	output logic o_axi_arvalid,
	output logic [ADDR_WIDTH-1:0] o_axi_araddr,
	output logic [2:0] o_axi_arprot
);

	// Byte address shared by AW and AR
	logic [ADDR_WIDTH-1:0] r_addr;

	////////////////////////////////////////
	// Channel valids
	////////////////////////////////////////

	// AW and W drop on their own readies
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_axi_awvalid <= 1'b0;
			o_axi_wvalid <= 1'b0;
			o_axi_arvalid <= 1'b0;
		end
		else if (i_load)
		begin
			o_axi_awvalid <= i_write;
			o_axi_wvalid <= i_write;
			o_axi_arvalid <= !i_write;
		end
		else
		begin
			if (i_axi_awready)
				o_axi_awvalid <= 1'b0;
			if (i_axi_wready)
				o_axi_wvalid <= 1'b0;
			if (i_axi_arready)
				o_axi_arvalid <= 1'b0;
		end
	end

	// Payload held until the next load
	always_ff @(posedge i_clk)
	begin
		if (i_load)
		begin
			// Word address to byte address
			r_addr <= {i_wb_addr, 2'b00};
			o_axi_wdata <= i_wb_data;
			o_axi_wstrb <= i_wb_sel;
		end
	end

	assign o_axi_awaddr = r_addr;
	assign o_axi_araddr = r_addr;

	// Unprivileged, secure, data access
	assign o_axi_awprot = 3'b000;
	assign o_axi_arprot = 3'b000;

	// Busy until every raised valid is accepted
	assign o_busy = o_axi_awvalid || o_axi_wvalid || o_axi_arvalid;

endmodule

`default_nettype wire

//--- hw/axil_resp_return.sv
`timescale 1ns/1ps
`default_nettype none

module axil_resp_return (
	input wire i_clk,
	input wire i_axi_reset_n,

	// B and R channels
	input wire i_axi_bvalid,
	input wire wbaxi_pkg::axi_resp_t i_axi_bresp,
	input wire i_axi_rvalid,
	input wire wbaxi_pkg::axi_data_t i_axi_rdata,
	input wire wbaxi_pkg::axi_resp_t i_axi_rresp,

	output logic o_axi_bready,
	output logic o_axi_rready,
	output logic o_wb_ack,
	output logic o_wb_err,
	output wbaxi_pkg::axi_data_t o_wb_data,
	output logic o_done
);

	logic w_b_hs;
	logic w_r_hs;
	logic w_b_err;
	logic w_r_err;

	// Wishbone takes acks without back-pressure
	assign o_axi_bready = 1'b1;
	assign o_axi_rready = 1'b1;

	assign w_b_hs = i_axi_bvalid && o_axi_bready;
	assign w_r_hs = i_axi_rvalid && o_axi_rready;

	// SLVERR or DECERR, upper bit set
	assign w_b_err = (i_axi_bresp == wbaxi_pkg::RESP_SLVERR)
		|| (i_axi_bresp == wbaxi_pkg::RESP_DECERR);
	assign w_r_err = (i_axi_rresp == wbaxi_pkg::RESP_SLVERR)
		|| (i_axi_rresp == wbaxi_pkg::RESP_DECERR);

	// One cycle after the handshake
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_wb_ack <= 1'b0;
			o_wb_err <= 1'b0;
		end
		else
		begin
			o_wb_ack <= (w_b_hs && !w_b_err) || (w_r_hs && !w_r_err);
			o_wb_err <= (w_b_hs && w_b_err) || (w_r_hs && w_r_err);
		end
	end

	// Read word, valid alongside the ack
	always_ff @(posedge i_clk)
	begin
		if (w_r_hs)
			o_wb_data <= i_axi_rdata;
	end

	// Either outcome retires one request
	assign o_done = o_wb_ack || o_wb_err;

endmodule

`default_nettype wire

//--- hw/axil_txn_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module axil_txn_monitor #(
	parameter int ADDR_WIDTH = 28,
	parameter int LGDEPTH = 4,
	parameter int MAX_WAIT = 8
) (
	input wire i_clk,
	input wire i_axi_reset_n,

	input wire i_axi_awvalid,
	input wire i_axi_awready,
	input wire i_axi_wvalid,
	input wire i_axi_wready,
	input wire i_axi_bvalid,
	input wire i_axi_bready,
	input wire wbaxi_pkg::axi_resp_t i_axi_bresp,
	input wire i_axi_arvalid,
	input wire i_axi_arready,
	input wire i_axi_rvalid,
	input wire i_axi_rready,
	input wire wbaxi_pkg::axi_resp_t i_axi_rresp,

	output logic [LGDEPTH-1:0] o_rd_outstanding,
	output logic [LGDEPTH-1:0] o_awr_outstanding,
	output logic [LGDEPTH-1:0] o_wr_outstanding,
	output logic o_fault
);

	// Tracked channels, one counter each
	localparam int NCH = 3;
	localparam int CH_RD = 0;
	localparam int CH_AWR = 1;
	localparam int CH_WR = 2;
	localparam int SWIDTH = $clog2(MAX_WAIT + 1);
	localparam logic [LGDEPTH-1:0] CNT_FULL = '1;
	localparam logic [SWIDTH-1:0] STALL_LIMIT = SWIDTH'(MAX_WAIT);

	logic [NCH-1:0] w_req_valid;
	logic [NCH-1:0] w_req_ready;
	logic [NCH-1:0] w_req_hs;
	logic [NCH-1:0] w_rsp_valid;
	logic [NCH-1:0] w_rsp_hs;
	logic [NCH-1:0] w_stall_hit;
	logic [NCH-1:0] w_spurious;
	logic [NCH-1:0] w_overflow;
	logic w_bad_resp;
	logic w_violation;
	logic [LGDEPTH-1:0] r_count [NCH];
	logic [SWIDTH-1:0] r_stall [NCH];

	if ((ADDR_WIDTH < 3) || (LGDEPTH < 2) || (MAX_WAIT < 1))
	begin : g_param_check
		$error("axil_txn_monitor: bad ADDR_WIDTH, LGDEPTH or MAX_WAIT");
	end

	////////////////////////////////////////
	// Per-channel request and response
	////////////////////////////////////////

	assign w_req_valid[CH_RD] = i_axi_arvalid;
	assign w_req_ready[CH_RD] = i_axi_arready;
	assign w_req_valid[CH_AWR] = i_axi_awvalid;
	assign w_req_ready[CH_AWR] = i_axi_awready;
	assign w_req_valid[CH_WR] = i_axi_wvalid;
	assign w_req_ready[CH_WR] = i_axi_wready;
	assign w_req_hs = w_req_valid & w_req_ready;

	// B retires both AW and W
	assign w_rsp_valid[CH_RD] = i_axi_rvalid;
	assign w_rsp_hs[CH_RD] = i_axi_rvalid && i_axi_rready;
	assign w_rsp_valid[CH_AWR] = i_axi_bvalid;
	assign w_rsp_hs[CH_AWR] = i_axi_bvalid && i_axi_bready;
	assign w_rsp_valid[CH_WR] = i_axi_bvalid;
	assign w_rsp_hs[CH_WR] = i_axi_bvalid && i_axi_bready;

	////////////////////////////////////////
	// Outstanding and stall counters
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		for (int i = 0; i < NCH; i++)
		begin
			if (!i_axi_reset_n)
				r_count[i] <= '0;
			else if (w_req_hs[i] && !w_rsp_hs[i])
				r_count[i] <= r_count[i] + 1'b1;
			else if (!w_req_hs[i] && w_rsp_hs[i])
				r_count[i] <= r_count[i] - 1'b1;
			// Stalled cycles, saturating at the limit
			if (!i_axi_reset_n || !w_req_valid[i] || w_req_ready[i])
				r_stall[i] <= '0;
			else if (r_stall[i] != STALL_LIMIT)
				r_stall[i] <= r_stall[i] + 1'b1;
		end
	end

	assign o_rd_outstanding = r_count[CH_RD];
	assign o_awr_outstanding = r_count[CH_AWR];
	assign o_wr_outstanding = r_count[CH_WR];

	////////////////////////////////////////
	// Violations and sticky fault
	////////////////////////////////////////

	always_comb
	begin
		for (int i = 0; i < NCH; i++)
		begin
			w_stall_hit[i] = (r_stall[i] == STALL_LIMIT);
			// Response with nothing outstanding
			w_spurious[i] = w_rsp_valid[i] && (r_count[i] == '0) && !w_req_hs[i];
			w_overflow[i] = (r_count[i] == CNT_FULL);
		end
	end

	// Exclusive okay without exclusive access
	assign w_bad_resp = (i_axi_bvalid && (i_axi_bresp == wbaxi_pkg::RESP_EXOKAY))
		|| (i_axi_rvalid && (i_axi_rresp == wbaxi_pkg::RESP_EXOKAY));

	assign w_violation = (|w_stall_hit) || (|w_spurious) || (|w_overflow) || w_bad_resp;

	// Stays set until reset
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			o_fault <= 1'b0;
		else if (w_violation)
			o_fault <= 1'b1;
	end

endmodule

`default_nettype wire

//--- hw/wbaxi_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module wbaxi_bridge_top #(
	parameter int ADDR_WIDTH = 28,
	parameter int LGDEPTH = 4,
	parameter int MAX_WAIT = 8
) (
	input wire i_clk,
	input wire i_axi_reset_n,

	// Wishbone pipelined slave
	input wire i_wb_cyc,
	input wire i_wb_stb,
	input wire i_wb_we,
	input wire [ADDR_WIDTH-3:0] i_wb_addr,
	input wire wbaxi_pkg::axi_data_t i_wb_data,
	input wire wbaxi_pkg::axi_strb_t i_wb_sel,
	output logic o_wb_stall,
	output logic o_wb_ack,
	output wbaxi_pkg::axi_data_t o_wb_data,
	output logic o_wb_err,

	// AXI-lite master
	output logic o_axi_awvalid,
	input wire i_axi_awready,
	output logic [ADDR_WIDTH-1:0] o_axi_awaddr,
	output logic [2:0] o_axi_awprot,
	output logic o_axi_wvalid,
	input wire i_axi_wready,
	output wbaxi_pkg::axi_data_t o_axi_wdata,
	output wbaxi_pkg::axi_strb_t o_axi_wstrb,
	input wire i_axi_bvalid,
	output logic o_axi_bready,
	input wire wbaxi_pkg::axi_resp_t i_axi_bresp,
	output logic o_axi_arvalid,
	input wire i_axi_arready,
	output logic [ADDR_WIDTH-1:0] o_axi_araddr,
	output logic [2:0] o_axi_arprot,
	input wire i_axi_rvalid,
	output logic o_axi_rready,
	input wire wbaxi_pkg::axi_data_t i_axi_rdata,
	input wire wbaxi_pkg::axi_resp_t i_axi_rresp,

	// Monitor status
	output logic o_mon_fault,
	output logic [LGDEPTH-1:0] o_rd_outstanding,
	output logic [LGDEPTH-1:0] o_awr_outstanding,
	output logic [LGDEPTH-1:0] o_wr_outstanding
);

	wire w_issue_load;
	wire w_issue_write;
	wire w_issue_busy;
	wire w_resp_done;

	////////////////////////////////////////
	// Control and datapath
	////////////////////////////////////////

	wbaxi_ctrl #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.LGDEPTH(LGDEPTH)
	) i_wbaxi_ctrl (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
		.i_issue_busy(w_issue_busy), .i_resp_done(w_resp_done),
		.o_wb_stall(o_wb_stall),
		.o_issue_load(w_issue_load), .o_issue_write(w_issue_write)
	);

	// Address, data and select straight off Wishbone
	axil_req_issue #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) i_axil_req_issue (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_load(w_issue_load), .i_write(w_issue_write),
		.i_wb_addr(i_wb_addr), .i_wb_data(i_wb_data), .i_wb_sel(i_wb_sel),
		.i_axi_awready(i_axi_awready), .i_axi_wready(i_axi_wready),
		.i_axi_arready(i_axi_arready),
		.o_busy(w_issue_busy),
		.o_axi_awvalid(o_axi_awvalid), .o_axi_awaddr(o_axi_awaddr),
		.o_axi_awprot(o_axi_awprot),
		.o_axi_wvalid(o_axi_wvalid), .o_axi_wdata(o_axi_wdata),
		.o_axi_wstrb(o_axi_wstrb),
		.o_axi_arvalid(o_axi_arvalid), .o_axi_araddr(o_axi_araddr),
		.o_axi_arprot(o_axi_arprot)
	);

	axil_resp_return i_axil_resp_return (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_axi_bvalid(i_axi_bvalid), .i_axi_bresp(i_axi_bresp),
		.i_axi_rvalid(i_axi_rvalid), .i_axi_rdata(i_axi_rdata),
		.i_axi_rresp(i_axi_rresp),
		.o_axi_bready(o_axi_bready), .o_axi_rready(o_axi_rready),
		.o_wb_ack(o_wb_ack), .o_wb_err(o_wb_err), .o_wb_data(o_wb_data),
		.o_done(w_resp_done)
	);

	////////////////////////////////////////
	// Bus watch
	////////////////////////////////////////

	axil_txn_monitor #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.LGDEPTH(LGDEPTH),
		.MAX_WAIT(MAX_WAIT)
	) i_axil_txn_monitor (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_axi_awvalid(o_axi_awvalid), .i_axi_awready(i_axi_awready),
		.i_axi_wvalid(o_axi_wvalid), .i_axi_wready(i_axi_wready),
		.i_axi_bvalid(i_axi_bvalid), .i_axi_bready(o_axi_bready),
		.i_axi_bresp(i_axi_bresp),
		.i_axi_arvalid(o_axi_arvalid), .i_axi_arready(i_axi_arready),
		.i_axi_rvalid(i_axi_rvalid), .i_axi_rready(o_axi_rready),
		.i_axi_rresp(i_axi_rresp),
		.o_rd_outstanding(o_rd_outstanding),
		.o_awr_outstanding(o_awr_outstanding),
		.o_wr_outstanding(o_wr_outstanding),
		.o_fault(o_mon_fault)
	);

endmodule

`default_nettype wire

//--- hw/wbaxi_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module wbaxi_ctrl #(
	parameter int ADDR_WIDTH = 28,
	parameter int LGDEPTH = 4
) (
	input wire i_clk,
	input wire i_axi_reset_n,

	// Wishbone request side
	input wire i_wb_cyc,
	input wire i_wb_stb,
	input wire i_wb_we,

	// From issuer and response return
	input wire i_issue_busy,
	input wire i_resp_done,

	output logic o_wb_stall,
	output logic o_issue_load,
	output logic o_issue_write
);

	// Pending limit, all ones less one
	localparam logic [LGDEPTH-1:0] PEND_MAX = {LGDEPTH{1'b1}} - 1'b1;

	wbaxi_pkg::ctrl_state_t r_state;
	logic [LGDEPTH-1:0] r_pending;
	logic [LGDEPTH-1:0] w_pending_next;
	logic w_request;
	logic w_full;
	logic w_dir_change;

	// Need a word address and a counter of some depth
	if ((ADDR_WIDTH < 3) || (LGDEPTH < 2))
	begin : g_param_check
		$error("wbaxi_ctrl: ADDR_WIDTH must be >= 3 and LGDEPTH >= 2");
	end

	////////////////////////////////////////
	// Stall decision
	////////////////////////////////////////

	assign w_request = i_wb_cyc && i_wb_stb;

	// Counter one short of all ones
	assign w_full = (r_pending >= PEND_MAX);

	// Request direction against the current one
	always_comb
	begin
		case (r_state)
		wbaxi_pkg::ST_WRITE:
			w_dir_change = !i_wb_we;
		wbaxi_pkg::ST_READ:
			w_dir_change = i_wb_we;
		default:
			w_dir_change = 1'b0;
		endcase
	end

	// Hold off while the issuer is busy, the counter is full,
	// or a turnaround must wait for pending responses
	assign o_wb_stall = i_issue_busy
		|| w_full
		|| (w_request && (r_pending != '0) && w_dir_change);

	// One load per accepted request
	assign o_issue_load = w_request && !o_wb_stall;
	assign o_issue_write = i_wb_we;

	////////////////////////////////////////
	// Pending count and direction
	////////////////////////////////////////

	// Up on load, down on done, both cancel
	always_comb
	begin
		w_pending_next = r_pending;
		if (o_issue_load && !i_resp_done)
			w_pending_next = r_pending + 1'b1;
		else if (!o_issue_load && i_resp_done)
			w_pending_next = r_pending - 1'b1;
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			r_pending <= '0;
			r_state <= wbaxi_pkg::ST_IDLE;
		end
		else
		begin
			r_pending <= w_pending_next;
			// New request sets the direction
			if (o_issue_load)
			begin
				if (i_wb_we)
					r_state <= wbaxi_pkg::ST_WRITE;
				else
					r_state <= wbaxi_pkg::ST_READ;
			end
			// Last response back, direction free again
			else if (w_pending_next == '0)
				r_state <= wbaxi_pkg::ST_IDLE;
		end
	end

endmodule

`default_nettype wire

//--- hw/wbaxi_pkg.sv
`default_nettype none

package wbaxi_pkg;

	////////////////////////////////////////
	// Bus word types
	////////////////////////////////////////

	// One data word, AXI and Wishbone alike
	typedef logic [31:0] axi_data_t;

	// Byte lane strobe, doubles as Wishbone select
	typedef logic [3:0] axi_strb_t;

	// AXI response code
	typedef logic [1:0] axi_resp_t;

	////////////////////////////////////////
	// Response codes
	////////////////////////////////////////

	localparam axi_resp_t RESP_OKAY = 2'b00;
	// Exclusive okay, never legal on this bus
	localparam axi_resp_t RESP_EXOKAY = 2'b01;
	// Both error codes carry the upper bit
	localparam axi_resp_t RESP_SLVERR = 2'b10;
	localparam axi_resp_t RESP_DECERR = 2'b11;

	////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////

	// Direction of the requests in flight
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WRITE,
		ST_READ
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the bridge testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_wbaxi_bridge -Mdir "$OBJ" -f files.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/Vtb_wbaxi_bridge" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -F -q "Test failed" "$LOG"; then
	exit 1
fi
exit 0

//--- testbench/tb_wbaxi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wbaxi_bridge;

	localparam int ADDR_WIDTH = 28;
	localparam int LGDEPTH = 4;
	localparam int MAX_WAIT = 8;
	localparam int WBA = ADDR_WIDTH - 2;
	localparam int MEM_WORDS = 16;
	localparam int NUM_TESTS = 11;
	localparam int RESET_CYCLES = 8;
	localparam int TEST_BOUND = 20;
	// Table plus the two end checks, each within one test bound
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + (NUM_TESTS + 2) * TEST_BOUND;

	logic i_clk;
	logic i_axi_reset_n;
	logic i_wb_cyc;
	logic i_wb_stb;
	logic i_wb_we;
	logic [WBA-1:0] i_wb_addr;
	wbaxi_pkg::axi_data_t i_wb_data;
	wbaxi_pkg::axi_strb_t i_wb_sel;
	wire o_wb_stall;
	wire o_wb_ack;
	wire o_wb_err;
	wbaxi_pkg::axi_data_t o_wb_data;

	// AXI-lite slave model drives these
	logic i_axi_awready = 1'b0;
	logic i_axi_wready = 1'b0;
	logic i_axi_bvalid = 1'b0;
	wbaxi_pkg::axi_resp_t i_axi_bresp = '0;
	logic i_axi_arready = 1'b0;
	logic i_axi_rvalid = 1'b0;
	wbaxi_pkg::axi_data_t i_axi_rdata = '0;
	wbaxi_pkg::axi_resp_t i_axi_rresp = '0;
	wire o_axi_awvalid;
	wire [ADDR_WIDTH-1:0] o_axi_awaddr;
	wire [2:0] o_axi_awprot;
	wire o_axi_wvalid;
	wbaxi_pkg::axi_data_t o_axi_wdata;
	wbaxi_pkg::axi_strb_t o_axi_wstrb;
	wire o_axi_bready;
	wire o_axi_arvalid;
	wire [ADDR_WIDTH-1:0] o_axi_araddr;
	wire [2:0] o_axi_arprot;
	wire o_axi_rready;
	wire o_mon_fault;
	wire [LGDEPTH-1:0] o_rd_outstanding;
	wire [LGDEPTH-1:0] o_awr_outstanding;
	wire [LGDEPTH-1:0] o_wr_outstanding;

	// Stimulus and expected results, one row per test
	string t_name [NUM_TESTS];
	logic t_we [NUM_TESTS];
	logic [WBA-1:0] t_addr [NUM_TESTS];
	wbaxi_pkg::axi_data_t t_data [NUM_TESTS];
	wbaxi_pkg::axi_strb_t t_sel [NUM_TESTS];
	logic t_exp_err [NUM_TESTS];
	wbaxi_pkg::axi_data_t t_exp_data [NUM_TESTS];
	int n_tests = 0;
	// Expected memory contents while the table is built
	wbaxi_pkg::axi_data_t shadow [MEM_WORDS];

	// Slave model state
	wbaxi_pkg::axi_data_t mem [MEM_WORDS];
	wbaxi_pkg::axi_resp_t b_resp_q [$];
	wbaxi_pkg::axi_data_t r_data_q [$];
	wbaxi_pkg::axi_resp_t r_resp_q [$];
	int aw_wait;
	int ar_wait;
	int b_wait;
	int r_wait;
	int wr_word;
	int rd_word;
	logic inject_b = 1'b0;
	logic injected = 1'b0;

	int cycle_count = 0;
	int resp_count = 0;
	int pass_count = 0;
	int fail_count = 0;

	wbaxi_bridge_top #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.LGDEPTH(LGDEPTH),
		.MAX_WAIT(MAX_WAIT)
	) i_wbaxi_bridge_top (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
		.i_wb_addr(i_wb_addr), .i_wb_data(i_wb_data), .i_wb_sel(i_wb_sel),
		.o_wb_stall(o_wb_stall), .o_wb_ack(o_wb_ack), .o_wb_data(o_wb_data),
		.o_wb_err(o_wb_err),
		.o_axi_awvalid(o_axi_awvalid), .i_axi_awready(i_axi_awready),
		.o_axi_awaddr(o_axi_awaddr), .o_axi_awprot(o_axi_awprot),
		.o_axi_wvalid(o_axi_wvalid), .i_axi_wready(i_axi_wready),
		.o_axi_wdata(o_axi_wdata), .o_axi_wstrb(o_axi_wstrb),
		.i_axi_bvalid(i_axi_bvalid), .o_axi_bready(o_axi_bready),
		.i_axi_bresp(i_axi_bresp),
		.o_axi_arvalid(o_axi_arvalid), .i_axi_arready(i_axi_arready),
		.o_axi_araddr(o_axi_araddr), .o_axi_arprot(o_axi_arprot),
		.i_axi_rvalid(i_axi_rvalid), .o_axi_rready(o_axi_rready),
		.i_axi_rdata(i_axi_rdata), .i_axi_rresp(i_axi_rresp),
		.o_mon_fault(o_mon_fault), .o_rd_outstanding(o_rd_outstanding),
		.o_awr_outstanding(o_awr_outstanding), .o_wr_outstanding(o_wr_outstanding)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	////////////////////////////////////////
	// Reference rules
	////////////////////////////////////////

	// Power-up contents, a function of the full word address
	function automatic wbaxi_pkg::axi_data_t fill_word(input int word);
		logic [15:0] w;
		w = word[15:0];
		return {~w, w} ^ 32'h5A5A_3C3C;
	endfunction

	// Selected bytes from the new word, the rest kept
	function automatic wbaxi_pkg::axi_data_t merge_bytes(input wbaxi_pkg::axi_data_t old_w,
		input wbaxi_pkg::axi_data_t new_w, input wbaxi_pkg::axi_strb_t sel);
		wbaxi_pkg::axi_data_t mask;
		mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		return (old_w & ~mask) | (new_w & mask);
	endfunction

	function automatic string kind_name(input logic is_err);
		return is_err ? "err" : "ack";
	endfunction

	// Out-of-range words answer SLVERR
	task automatic add_test(input string name, input logic we, input int addr,
		input wbaxi_pkg::axi_data_t data, input wbaxi_pkg::axi_strb_t sel);
		t_name[n_tests] = name;
		t_we[n_tests] = we;
		t_addr[n_tests] = WBA'(addr);
		t_data[n_tests] = data;
		t_sel[n_tests] = sel;
		t_exp_err[n_tests] = (addr >= MEM_WORDS);
		t_exp_data[n_tests] = '0;
		if (addr < MEM_WORDS)
		begin
			if (we)
				shadow[addr] = merge_bytes(shadow[addr], data, sel);
			else
				t_exp_data[n_tests] = shadow[addr];
		end
		n_tests++;
	endtask

	task automatic build_table();
		for (int k = 0; k < MEM_WORDS; k++)
			shadow[k] = fill_word(k);
		add_test("wr_full", 1'b1, 3, 32'hDEAD_BEEF, 4'hF);
		add_test("rd_full", 1'b0, 3, '0, 4'hF);
		add_test("wr_part", 1'b1, 3, 32'h1122_3344, 4'b0101);
		add_test("rd_part", 1'b0, 3, '0, 4'hF);
		add_test("wr_err", 1'b1, 20, 32'h0BAD_0BAD, 4'hF);
		add_test("rd_err", 1'b0, 17, '0, 4'hF);
		// Reads back to back, then a write straight after
		add_test("rd_b2b0", 1'b0, 0, '0, 4'hF);
		add_test("rd_b2b1", 1'b0, 5, '0, 4'hF);
		add_test("rd_b2b2", 1'b0, 15, '0, 4'hF);
		add_test("wr_after", 1'b1, 5, 32'hCAFE_F00D, 4'hF);
		add_test("rd_after", 1'b0, 5, '0, 4'hF);
	endtask

	////////////////////////////////////////
	// AXI-lite memory slave
	////////////////////////////////////////

	always @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			i_axi_awready <= 1'b0;
			i_axi_wready <= 1'b0;
			i_axi_arready <= 1'b0;
			i_axi_bvalid <= 1'b0;
			i_axi_rvalid <= 1'b0;
			injected <= 1'b0;
			b_resp_q.delete();
			r_data_q.delete();
			r_resp_q.delete();
			for (int k = 0; k < MEM_WORDS; k++)
				mem[k] <= fill_word(k);
			aw_wait = $urandom_range(2, 0);
			ar_wait = $urandom_range(2, 0);
			b_wait = $urandom_range(2, 0);
			r_wait = $urandom_range(2, 0);
		end
		else
		begin
			// B beat 1 to 3 cycles after the write
			if (i_axi_bvalid && o_axi_bready)
				i_axi_bvalid <= 1'b0;
			else if (b_resp_q.size() != 0)
			begin
				if (b_wait == 0)
				begin
					i_axi_bvalid <= 1'b1;
					i_axi_bresp <= b_resp_q.pop_front();
					b_wait = $urandom_range(2, 0);
				end
				else
					b_wait--;
			end
			else if (inject_b && !injected)
			begin
				// Unsolicited, nothing outstanding
				i_axi_bvalid <= 1'b1;
				i_axi_bresp <= wbaxi_pkg::RESP_OKAY;
				injected <= 1'b1;
			end
			// R beat, same latency rule
			if (i_axi_rvalid && o_axi_rready)
				i_axi_rvalid <= 1'b0;
			else if (r_resp_q.size() != 0)
			begin
				if (r_wait == 0)
				begin
					i_axi_rvalid <= 1'b1;
					i_axi_rdata <= r_data_q.pop_front();
					i_axi_rresp <= r_resp_q.pop_front();
					r_wait = $urandom_range(2, 0);
				end
				else
					r_wait--;
			end
			// AW and W taken together
			if (i_axi_awready && o_axi_awvalid)
			begin
				i_axi_awready <= 1'b0;
				i_axi_wready <= 1'b0;
				// Plain data access, no protection bits
				assert (o_axi_awprot == 3'b000)
				else
				begin
					$display("[FAIL] awprot: expected 0x0, actual 0x%0h", o_axi_awprot);
					fail_count++;
				end
				wr_word = int'(o_axi_awaddr[ADDR_WIDTH-1:2]);
				if (wr_word < MEM_WORDS)
				begin
					for (int b = 0; b < 4; b++)
						if (o_axi_wstrb[b])
							mem[wr_word][8*b +: 8] <= o_axi_wdata[8*b +: 8];
					b_resp_q.push_back(wbaxi_pkg::RESP_OKAY);
				end
				else
					b_resp_q.push_back(wbaxi_pkg::RESP_SLVERR);
			end
			else if (o_axi_awvalid && o_axi_wvalid)
			begin
				if (aw_wait == 0)
				begin
					i_axi_awready <= 1'b1;
					i_axi_wready <= 1'b1;
					aw_wait = $urandom_range(2, 0);
				end
				else
					aw_wait--;
			end
			// AR, data looked up at the handshake
			if (i_axi_arready && o_axi_arvalid)
			begin
				i_axi_arready <= 1'b0;
				assert (o_axi_arprot == 3'b000)
				else
				begin
					$display("[FAIL] arprot: expected 0x0, actual 0x%0h", o_axi_arprot);
					fail_count++;
				end
				rd_word = int'(o_axi_araddr[ADDR_WIDTH-1:2]);
				if (rd_word < MEM_WORDS)
				begin
					r_data_q.push_back(mem[rd_word]);
					r_resp_q.push_back(wbaxi_pkg::RESP_OKAY);
				end
				else
				begin
					r_data_q.push_back('0);
					r_resp_q.push_back(wbaxi_pkg::RESP_SLVERR);
				end
			end
			else if (o_axi_arvalid)
			begin
				if (ar_wait == 0)
				begin
					i_axi_arready <= 1'b1;
					ar_wait = $urandom_range(2, 0);
				end
				else
					ar_wait--;
			end
		end
	end

	////////////////////////////////////////
	// Wishbone master and checks
	////////////////////////////////////////

	// Cycle limit and response tally
	always @(posedge i_clk)
	begin
		cycle_count <= cycle_count + 1;
		if (o_wb_ack || o_wb_err)
			resp_count <= resp_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: run exceeded %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	task automatic report_result(input string name, input bit ok);
		if (ok)
		begin
			$display("[PASS] %s", name);
			pass_count++;
		end
		else
			fail_count++;
	endtask

	// Next request goes out once the current one is taken
	task automatic issue_requests();
		for (int i = 0; i < n_tests; i++)
		begin
			@(posedge i_clk);
			i_wb_cyc <= 1'b1;
			i_wb_stb <= 1'b1;
			i_wb_we <= t_we[i];
			i_wb_addr <= t_addr[i];
			i_wb_data <= t_data[i];
			i_wb_sel <= t_sel[i];
			@(negedge i_clk);
			while (o_wb_stall)
				@(negedge i_clk);
		end
		@(posedge i_clk);
		i_wb_stb <= 1'b0;
	endtask

	// Responses must arrive in table order
	task automatic collect_responses();
		bit ok;
		logic got_err;
		for (int i = 0; i < n_tests; i++)
		begin
			do
				@(negedge i_clk);
			while (!(o_wb_ack || o_wb_err));
			ok = 1'b1;
			got_err = o_wb_err;
			assert (got_err == t_exp_err[i])
			else
			begin
				$display("[FAIL] %s: expected %s, actual %s", t_name[i],
					kind_name(t_exp_err[i]), kind_name(got_err));
				ok = 1'b0;
			end
			if (ok && !t_we[i] && !got_err)
			begin
				assert (o_wb_data == t_exp_data[i])
				else
				begin
					$display("[FAIL] %s: expected 0x%08h, actual 0x%08h", t_name[i],
						t_exp_data[i], o_wb_data);
					ok = 1'b0;
				end
			end
			report_result(t_name[i], ok);
		end
	endtask

	initial
	begin
		bit ok;
		void'($urandom(32'h8e8a_6ce5));
		i_axi_reset_n = 1'b0;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
		i_wb_addr = '0;
		i_wb_data = '0;
		i_wb_sel = '0;
		build_table();
		repeat (RESET_CYCLES) @(posedge i_clk);
		i_axi_reset_n <= 1'b1;

		fork
			issue_requests();
			collect_responses();
		join
		@(posedge i_clk);
		i_wb_cyc <= 1'b0;
		repeat (4) @(negedge i_clk);

		// Monitor idle and clean, one response per request
		ok = 1'b1;
		assert (o_rd_outstanding == '0)
		else
		begin
			$display("[FAIL] end_state rd: expected 0, actual %0d", o_rd_outstanding);
			ok = 1'b0;
		end
		assert (o_awr_outstanding == '0)
		else
		begin
			$display("[FAIL] end_state awr: expected 0, actual %0d", o_awr_outstanding);
			ok = 1'b0;
		end
		assert (o_wr_outstanding == '0)
		else
		begin
			$display("[FAIL] end_state wr: expected 0, actual %0d", o_wr_outstanding);
			ok = 1'b0;
		end
		assert (!o_mon_fault)
		else
		begin
			$display("[FAIL] end_state fault: expected 0, actual %0b", o_mon_fault);
			ok = 1'b0;
		end
		assert (resp_count == n_tests)
		else
		begin
			$display("[FAIL] end_state responses: expected %0d, actual %0d",
				n_tests, resp_count);
			ok = 1'b0;
		end
		report_result("end_state", ok);

		// Stray B beat must trip the monitor
		@(posedge i_clk);
		inject_b <= 1'b1;
		repeat (4) @(negedge i_clk);
		ok = 1'b1;
		assert (o_mon_fault)
		else
		begin
			$display("[FAIL] spurious_b: expected 1, actual %0b", o_mon_fault);
			ok = 1'b0;
		end
		report_result("spurious_b", ok);

		$display("Summary: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/wbaxi_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module wbaxi_assertions #(
	parameter int ADDR_WIDTH = 28
) (
	input wire i_clk,
	input wire i_axi_reset_n,
	input wire wbaxi_pkg::ctrl_state_t i_ctrl_state,
	input wire i_axi_awvalid,
	input wire i_axi_awready,
	input wire [ADDR_WIDTH-1:0] i_axi_awaddr,
	input wire i_axi_wvalid,
	input wire i_axi_wready,
	input wire wbaxi_pkg::axi_data_t i_axi_wdata,
	input wire wbaxi_pkg::axi_strb_t i_axi_wstrb,
	input wire i_axi_arvalid,
	input wire i_axi_arready,
	input wire [ADDR_WIDTH-1:0] i_axi_araddr,
	input wire i_wb_ack,
	input wire i_wb_err
);

	////////////////////////////////////////
	// Reset and handshake rules
	////////////////////////////////////////

	// Valids come out of reset low
	a_reset_valids: assert property (@(posedge i_clk)
		!i_axi_reset_n |=> !(i_axi_awvalid || i_axi_wvalid || i_axi_arvalid))
		else $error("AXI valid high in the cycle after reset");

	// Held valid keeps its payload
	a_aw_hold: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		i_axi_awvalid && !i_axi_awready |=> i_axi_awvalid && $stable(i_axi_awaddr))
		else $error("AW valid or address changed before ready");
	a_w_hold: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		i_axi_wvalid && !i_axi_wready
		|=> i_axi_wvalid && $stable(i_axi_wdata) && $stable(i_axi_wstrb))
		else $error("W valid or payload changed before ready");
	a_ar_hold: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		i_axi_arvalid && !i_axi_arready |=> i_axi_arvalid && $stable(i_axi_araddr))
		else $error("AR valid or address changed before ready");

	////////////////////////////////////////
	// Wishbone and direction
	////////////////////////////////////////

	a_ack_err: assert property (@(posedge i_clk) !(i_wb_ack && i_wb_err))
		else $error("Wishbone ack and err high together");

	// No read on the bus while writes own it, and the reverse
	a_dir_write: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(i_ctrl_state == wbaxi_pkg::ST_WRITE) |-> !i_axi_arvalid)
		else $error("AR valid while the bridge is in write direction");
	a_dir_read: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(i_ctrl_state == wbaxi_pkg::ST_READ) |-> !(i_axi_awvalid || i_axi_wvalid))
		else $error("AW or W valid while the bridge is in read direction");

endmodule

bind wbaxi_bridge_top wbaxi_assertions #(
	.ADDR_WIDTH(ADDR_WIDTH)
) i_wbaxi_assertions (
	.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
	.i_ctrl_state(i_wbaxi_ctrl.r_state),
	.i_axi_awvalid(o_axi_awvalid), .i_axi_awready(i_axi_awready),
	.i_axi_awaddr(o_axi_awaddr),
	.i_axi_wvalid(o_axi_wvalid), .i_axi_wready(i_axi_wready),
	.i_axi_wdata(o_axi_wdata), .i_axi_wstrb(o_axi_wstrb),
	.i_axi_arvalid(o_axi_arvalid), .i_axi_arready(i_axi_arready),
	.i_axi_araddr(o_axi_araddr),
	.i_wb_ack(o_wb_ack), .i_wb_err(o_wb_err)
);

`default_nettype wire
